//--- bench/iss_model.svh
// ------------------------------
// instruction-level reference model, included in the
// testbench body, replays imem and fills the expected
// store queues
// ------------------------------

// returns the number of retired instructions, -1 without HALT
function automatic int run_model(input int max_steps);
  logic [31:0] regs [32];
  logic [31:0] mem [DMEM_WORDS];
  logic [31:0] pc, ins, a, b, simm, zimm, ea, res, next_pc;
  logic [4:0]  rd;
  logic        wr;
  opcode_t     op;
  funct_t      fn;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    mem[i] = dmem_init[i];
  end
  exp_addr.delete();
  exp_data.delete();
  pc = '0;
  for (int step = 0; step < max_steps; step++) begin
    ins     = imem[pc[IMEM_AW+1:2]];
    op      = opcode_t'(ins[31:26]);
    fn      = funct_t'(ins[5:0]);
    a       = regs[ins[25:21]];  // rs
    b       = regs[ins[20:16]];  // rt
    simm    = {{16{ins[15]}}, ins[15:0]};
    zimm    = {16'h0000, ins[15:0]};
    ea      = a + simm;
    next_pc = pc + 4;
    rd      = ins[20:16];
    res     = '0;
    wr      = 1'b0;
    case (op)
      OP_RTYPE: begin
        rd = ins[15:11];
        wr = 1'b1;
        case (fn)
          FN_ADDU: res = a + b;
          FN_SUBU: res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLL:  res = b << ins[10:6];
          FN_JR: begin
            wr      = 1'b0;
            next_pc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        res = a + simm;
        wr  = 1'b1;
      end
      OP_ORI: begin
        res = a | zimm;
        wr  = 1'b1;
      end
      OP_LUI: begin
        res = {ins[15:0], 16'h0000};
        wr  = 1'b1;
      end
      OP_LW: begin
        res = mem[ea[DMEM_AW+1:2]];
        wr  = 1'b1;
      end
      OP_SW: begin
        exp_addr.push_back(ea);
        exp_data.push_back(b);
        mem[ea[DMEM_AW+1:2]] = b;
      end
      OP_BEQ:  if (a == b) next_pc = next_pc + (simm << 2);
      OP_BNE:  if (a != b) next_pc = next_pc + (simm << 2);
      OP_J:    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
      OP_JAL: begin
        res     = pc + 4;  // link
        rd      = 5'd31;
        wr      = 1'b1;
        next_pc = {next_pc[31:28], ins[25:0], 2'b00};
      end
      OP_HALT: return step;
      default: ;
    endcase
    if (wr && rd != 5'd0) regs[rd] = res;
    pc = next_pc;
  end
  return -1;
endfunction

//--- bench/tb_datapath.sv
// ------------------------------
// testbench for the pipelined datapath
// imem and dmem models answer after random delays
// and stores are checked against the ISS model
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module tb_datapath;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;

  localparam int IMEM_AW    = 6;
  localparam int DMEM_AW    = 8;
  localparam int IMEM_WORDS = 1 << IMEM_AW;
  localparam int DMEM_WORDS = 1 << DMEM_AW;
  localparam int HALT_LIMIT = 2000;  // cycles

  logic               CLK  = 1'b0;
  logic               nRST = 1'b0;
  logic               ihit = 1'b0;
  logic               dhit = 1'b0;
  logic [`DATA_W-1:0] imem_load = '0;
  logic [`DATA_W-1:0] dmem_load = '0;
  logic               imem_ren, dmem_ren, dmem_wen, halt;
  logic [`DATA_W-1:0] imem_addr, dmem_addr, dmem_store;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic [31:0] dmem_init [DMEM_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          seed = 32'hf920_5aaa;
  int          prog_len = 0;
  int          n_stores = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          model_steps, cycles;

  // open request of each memory
  logic        i_pend = 1'b0;
  logic        d_pend = 1'b0;
  int          i_wait = 0;
  int          d_wait = 0;
  logic [31:0] i_addr = '0;
  logic [31:0] d_addr = '0;

  datapath i_datapath (
    .CLK, .nRST, .imem_ren, .imem_addr, .imem_load, .ihit,
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .dmem_load, .dhit, .halt
  );

  always #4 CLK = ~CLK;

  `include "iss_model.svh"

  function automatic int draw_delay();
    return $unsigned($random(seed)) % 4;  // 0 to 3 cycles
  endfunction

  function automatic logic [31:0] rtype_word(funct_t fn, int rs, int rt, int rd, int sh);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] imm_word(opcode_t op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jump_word(opcode_t op, int target);
    return {op, 26'(target)};  // word index
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
      value_errs++;
    end
  endtask

  task automatic place(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {OP_HALT, 10'h000, 16'(i * 4)};  // stray fetch stops the core
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem_init[i] = 32'(i * 4) * 32'h9e37_79b1 ^ 32'h0bad_f00d;
      dmem[i]      = dmem_init[i];
    end
    place(imm_word(OP_ADDIU, 0, 1, 'h200));   // 0  store base
    place(imm_word(OP_LUI, 0, 2, 'h1234));    // 1
    place(imm_word(OP_ORI, 2, 2, 'h5678));    // 2  back to back chain
    place(imm_word(OP_ADDIU, 2, 3, -8));      // 3
    place(rtype_word(FN_SLL, 0, 3, 4, 4));    // 4
    place(rtype_word(FN_SUBU, 4, 2, 5, 0));   // 5
    place(rtype_word(FN_SLT, 5, 3, 6, 0));    // 6
    place(rtype_word(FN_AND, 5, 3, 7, 0));    // 7
    place(imm_word(OP_SW, 1, 7, 12));         // 8  store data forwarded
    place(imm_word(OP_SW, 1, 6, 8));          // 9
    place(imm_word(OP_SW, 1, 5, 4));          // 10
    place(imm_word(OP_SW, 1, 2, 0));          // 11
    place(imm_word(OP_LW, 0, 8, 'h40));       // 12
    place(rtype_word(FN_ADDU, 8, 2, 9, 0));   // 13 load-use
    place(imm_word(OP_SW, 1, 9, 16));         // 14
    place(imm_word(OP_ADDIU, 0, 0, 'h55));    // 15 r0 stays zero
    place(imm_word(OP_SW, 1, 0, 20));         // 16
    place(imm_word(OP_BEQ, 2, 3, 2));         // 17 not taken
    place(imm_word(OP_SW, 1, 4, 24));         // 18
    place(imm_word(OP_BNE, 2, 3, 2));         // 19 taken to 22
    place(imm_word(OP_SW, 1, 2, 28));         // 20 wrong path
    place(imm_word(OP_SW, 1, 3, 32));         // 21 wrong path
    place(imm_word(OP_BEQ, 0, 0, 2));         // 22 taken to 25
    place(imm_word(OP_SW, 1, 2, 36));         // 23 wrong path
    place(imm_word(OP_SW, 1, 2, 40));         // 24 wrong path
    place(jump_word(OP_JAL, 30));             // 25
    place(imm_word(OP_SW, 1, 31, 44));        // 26 return lands here
    place(jump_word(OP_J, 34));               // 27
    place(imm_word(OP_SW, 1, 2, 56));         // 28 wrong path
    place(imm_word(OP_SW, 1, 2, 60));         // 29 wrong path
    place(imm_word(OP_SW, 1, 31, 48));        // 30 link value
    place(rtype_word(FN_JR, 31, 0, 0, 0));    // 31
    place(imm_word(OP_SW, 1, 2, 64));         // 32 wrong path
    place(imm_word(OP_SW, 1, 2, 68));         // 33 wrong path
    place(imm_word(OP_BNE, 0, 0, 2));         // 34 not taken
    place(rtype_word(FN_OR, 9, 7, 10, 0));    // 35
    place(imm_word(OP_SW, 1, 10, 52));        // 36
    place(jump_word(OP_HALT, 0));             // 37
    place(imm_word(OP_SW, 1, 2, 72));         // 38 behind HALT
  endtask

  // ------------------------------
  // imem and dmem models
  always @(posedge CLK) begin
    #1;
    ihit = 1'b0;
    dhit = 1'b0;
    if (nRST && imem_ren) begin
      if (!i_pend || imem_addr != i_addr) begin
        i_addr = imem_addr;  // new fetch
        i_wait = draw_delay();
        i_pend = 1'b1;
      end
      if (i_wait == 0) begin
        ihit      = 1'b1;
        imem_load = imem[imem_addr[IMEM_AW+1:2]];
        i_pend    = 1'b0;
      end else begin
        i_wait--;
      end
    end
    if (nRST && (dmem_ren || dmem_wen)) begin
      if (!d_pend || dmem_addr != d_addr) begin
        d_addr = dmem_addr;
        d_wait = draw_delay();
        d_pend = 1'b1;
      end
      if (d_wait == 0) begin
        dhit   = 1'b1;
        d_pend = 1'b0;
        if (dmem_wen) begin
          dmem[dmem_addr[DMEM_AW+1:2]] = dmem_store;
        end else begin
          dmem_load = dmem[dmem_addr[DMEM_AW+1:2]];
        end
      end else begin
        d_wait--;
      end
    end
  end

  // ------------------------------
  // store checker at mid-cycle
  always @(negedge CLK) begin
    if (nRST && dmem_wen && dhit) begin
      if (n_stores < exp_addr.size()) begin
        check_value("dmem_addr", dmem_addr, exp_addr[n_stores]);
        check_value("dmem_store", dmem_store, exp_data[n_stores]);
      end else begin
        $display("unexpected store of %h to address %h after the last expected one",
                 dmem_store, dmem_addr);
        other_errs++;
      end
      n_stores++;
    end
  end

  initial begin
    load_program();
    model_steps = run_model(HALT_LIMIT);
    if (model_steps < 0) begin
      $display("reference model ran %0d steps without reaching HALT", HALT_LIMIT);
      other_errs++;
    end
    repeat (3) @(posedge CLK);
    #1 nRST = 1'b1;
    @(negedge CLK);
    check_value("dmem_ren", {31'b0, dmem_ren}, 32'h0);
    check_value("dmem_wen", {31'b0, dmem_wen}, 32'h0);
    check_value("halt", {31'b0, halt}, 32'h0);
    check_value("imem_ren", {31'b0, imem_ren}, 32'h1);
    check_value("imem_addr", imem_addr, 32'h0);  // reset vector

    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) begin
      $display("timeout, halt did not rise within %0d cycles", HALT_LIMIT);
      other_errs++;
    end else begin
      repeat (16) begin  // halt stays high and no store follows
        @(negedge CLK);
        check_value("halt", {31'b0, halt}, 32'h1);
        check_value("imem_ren", {31'b0, imem_ren}, 32'h0);
        check_value("dmem_wen", {31'b0, dmem_wen}, 32'h0);
      end
    end
    check_value("store count", n_stores, exp_addr.size());

    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/alu.sv
// ------------------------------
// execute-stage ALU, purely combinational
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module alu (
  input  logic [`DATA_W-1:0] port_a,
  input  logic [`DATA_W-1:0] port_b,
  input  logic [4:0]         shamt,
  input  pipe_pkg::aluop_t   op,
  output logic [`DATA_W-1:0] result,
  output logic               zero
);
  import pipe_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      ALU_SLT: result = {{(`DATA_W-1){1'b0}}, $signed(port_a) < $signed(port_b)};
      ALU_SLL: result = port_b << shamt;  // rt shifted, rs ignored
      ALU_LUI: result = {port_b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  // branch compare uses SUB, so zero means equal
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hw/control_unit.sv
// ------------------------------
// instruction decoder, turns the word in decode
// into the control levels carried down the pipe
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module control_unit (
  input  logic [`DATA_W-1:0] instr,
  output logic               reg_wen,
  output logic               mem_ren,
  output logic               mem_wen,
  output logic               alu_src,
  output logic               reg_dst,
  output logic               ext_sign,
  output logic               is_branch,
  output logic               is_bne,
  output logic               is_jump,
  output logic               is_jr,
  output logic               is_halt,
  output pipe_pkg::aluop_t   alu_op,
  output pipe_pkg::wb_src_t  wb_src
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // no-op unless the opcode says otherwise
    reg_wen   = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    ext_sign  = 1'b0;
    is_branch = 1'b0;
    is_bne    = 1'b0;
    is_jump   = 1'b0;
    is_jr     = 1'b0;
    is_halt   = 1'b0;
    alu_op    = ALU_ADD;
    wb_src    = WB_ALU;
    case (opcode)
      OP_RTYPE: begin
        reg_dst = 1'b1;
        reg_wen = 1'b1;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLL:  alu_op = ALU_SLL;
          FN_JR: begin
            reg_wen = 1'b0;
            is_jr   = 1'b1;  // target is rs
          end
          default: reg_wen = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        reg_wen  = 1'b1;
        alu_src  = 1'b1;
        ext_sign = 1'b1;
      end
      OP_ORI: begin
        reg_wen = 1'b1;
        alu_src = 1'b1;
        alu_op  = ALU_OR;  // zero extended
      end
      OP_LUI: begin
        reg_wen = 1'b1;
        alu_src = 1'b1;
        alu_op  = ALU_LUI;
      end
      OP_LW: begin
        reg_wen  = 1'b1;
        mem_ren  = 1'b1;
        alu_src  = 1'b1;
        ext_sign = 1'b1;
        wb_src   = WB_MEM;
      end
      OP_SW: begin
        mem_wen  = 1'b1;
        alu_src  = 1'b1;
        ext_sign = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        is_branch = 1'b1;
        is_bne    = (opcode == OP_BNE);
        ext_sign  = 1'b1;  // word offset
        alu_op    = ALU_SUB;
      end
      OP_J: is_jump = 1'b1;
      OP_JAL: begin
        is_jump = 1'b1;
        reg_wen = 1'b1;
        wb_src  = WB_LINK;  // rd forced to r31 in decode
      end
      OP_HALT: is_halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cpu_defines.svh
// ------------------------------
// width constants for the core, included by
// the RTL and the testbench
// ------------------------------
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word
`define DATA_W 32

// register select width and register count
`define REG_AW 5
`define REG_COUNT 32

`endif

//--- hw/datapath.sv
// ------------------------------
// five-stage pipeline top, IF ID EX MEM WB,
// talks to instruction and data memory through
// strobe and hit ports, halt marks program end
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module datapath #(
  parameter logic [`DATA_W-1:0] PC_INIT = '0
) (
  input  logic               CLK,
  input  logic               nRST,
  output logic               imem_ren,
  output logic [`DATA_W-1:0] imem_addr,
  input  logic [`DATA_W-1:0] imem_load,
  input  logic               ihit,
  output logic               dmem_ren,
  output logic               dmem_wen,
  output logic [`DATA_W-1:0] dmem_addr,
  output logic [`DATA_W-1:0] dmem_store,
  input  logic [`DATA_W-1:0] dmem_load,
  input  logic               dhit,
  output logic               halt
);
  import pipe_pkg::*;

  logic [`DATA_W-1:0] pc, pc4, pc_next;
  logic               ifid_valid;
  logic [`DATA_W-1:0] ifid_instr, ifid_pc4;
  logic cu_reg_wen, cu_mem_ren, cu_mem_wen, cu_alu_src, cu_reg_dst, cu_ext_sign;
  logic cu_is_branch, cu_is_bne, cu_is_jump, cu_is_jr, cu_is_halt;
  aluop_t             cu_alu_op;
  wb_src_t            cu_wb_src;
  logic [`DATA_W-1:0] rf_rdat1, rf_rdat2, id_imm;
  logic [`REG_AW-1:0] id_rs, id_rt, id_wsel;
  logic idex_valid, idex_reg_wen, idex_mem_ren, idex_mem_wen, idex_alu_src;
  logic idex_is_branch, idex_is_bne, idex_is_jump, idex_is_jr, idex_is_halt;
  aluop_t             idex_alu_op;
  wb_src_t            idex_wb_src;
  logic [`DATA_W-1:0] idex_pc4, idex_rdat1, idex_rdat2, idex_imm;
  logic [`REG_AW-1:0] idex_rs, idex_rt, idex_wsel;
  logic [4:0]         idex_shamt;
  logic [25:0]        idex_jidx;
  fwd_sel_t           fwd_a, fwd_b;
  logic [`DATA_W-1:0] ex_a, ex_b, alu_b, alu_result, ex_target;
  logic               alu_zero, redirect;
  logic exmem_valid, exmem_reg_wen, exmem_mem_ren, exmem_mem_wen, exmem_is_halt;
  wb_src_t            exmem_wb_src;
  logic [`DATA_W-1:0] exmem_alu, exmem_store, exmem_pc4, exmem_fwd;
  logic [`REG_AW-1:0] exmem_wsel;
  logic               memwb_valid, memwb_reg_wen, memwb_is_halt, wb_wen;
  wb_src_t            memwb_wb_src;
  logic [`DATA_W-1:0] memwb_alu, memwb_load, memwb_pc4, wb_data;
  logic [`REG_AW-1:0] memwb_wsel;
  logic pc_en, ifid_en, ifid_flush, idex_en, idex_bubble, exmem_en, memwb_en, memwb_bubble;
  logic               halt_q, halt_pend;

  // ------------------------------
  // fetch
  assign pc4       = pc + 4;
  assign pc_next   = redirect ? ex_target : pc4;
  assign imem_ren  = !halt_q;
  assign imem_addr = pc;

  // HALT in EX or later, nothing younger may follow it
  assign halt_pend = (idex_valid & idex_is_halt) | (exmem_valid & exmem_is_halt)
                   | (memwb_valid & memwb_is_halt);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc         <= PC_INIT;
      ifid_valid <= 1'b0;
    end else begin
      if (pc_en && !halt_pend) pc <= pc_next;
      if (ifid_en) ifid_valid <= !ifid_flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (ifid_en) begin
      ifid_instr <= imem_load;
      ifid_pc4   <= pc4;
    end
  end

  // ------------------------------
  // decode
  control_unit u_control (
    .instr(ifid_instr), .reg_wen(cu_reg_wen), .mem_ren(cu_mem_ren), .mem_wen(cu_mem_wen),
    .alu_src(cu_alu_src), .reg_dst(cu_reg_dst), .ext_sign(cu_ext_sign),
    .is_branch(cu_is_branch), .is_bne(cu_is_bne), .is_jump(cu_is_jump), .is_jr(cu_is_jr),
    .is_halt(cu_is_halt), .alu_op(cu_alu_op), .wb_src(cu_wb_src)
  );

  assign id_rs   = ifid_instr[25:21];
  assign id_rt   = ifid_instr[20:16];
  assign id_imm  = cu_ext_sign ? {{(`DATA_W-16){ifid_instr[15]}}, ifid_instr[15:0]}
                               : {{(`DATA_W-16){1'b0}}, ifid_instr[15:0]};
  assign id_wsel = (cu_wb_src == WB_LINK) ? '1  // r31 link
                 : (cu_reg_dst ? ifid_instr[15:11] : id_rt);

  register_file u_regs (
    .CLK, .nRST, .wen(wb_wen), .wsel(memwb_wsel), .wdat(wb_data),
    .rsel1(id_rs), .rsel2(id_rt), .rdat1(rf_rdat1), .rdat2(rf_rdat2)
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) idex_valid <= 1'b0;
    else if (idex_en) idex_valid <= ifid_valid & !(idex_bubble | halt_pend);
  end

  always_ff @(posedge CLK) begin
    if (idex_en) begin
      idex_reg_wen   <= cu_reg_wen;
      idex_mem_ren   <= cu_mem_ren;
      idex_mem_wen   <= cu_mem_wen;
      idex_alu_src   <= cu_alu_src;
      idex_is_branch <= cu_is_branch;
      idex_is_bne    <= cu_is_bne;
      idex_is_jump   <= cu_is_jump;
      idex_is_jr     <= cu_is_jr;
      idex_is_halt   <= cu_is_halt;
      idex_alu_op    <= cu_alu_op;
      idex_wb_src    <= cu_wb_src;
      idex_pc4       <= ifid_pc4;
      idex_rdat1     <= rf_rdat1;
      idex_rdat2     <= rf_rdat2;
      idex_imm       <= id_imm;
      idex_rs        <= id_rs;
      idex_rt        <= id_rt;
      idex_wsel      <= id_wsel;
      idex_shamt     <= ifid_instr[10:6];
      idex_jidx      <= ifid_instr[25:0];
    end
  end

  // ------------------------------
  // execute
  forwarding_unit u_fwd (
    .ex_rs(idex_rs), .ex_rt(idex_rt), .mem_rd(exmem_wsel),
    .mem_wen(exmem_valid & exmem_reg_wen), .wb_rd(memwb_wsel), .wb_wen,
    .fwd_a, .fwd_b
  );

  always_comb begin
    case (fwd_a)
      FWD_EXMEM: ex_a = exmem_fwd;
      FWD_MEMWB: ex_a = wb_data;
      default:   ex_a = idex_rdat1;
    endcase
    case (fwd_b)
      FWD_EXMEM: ex_b = exmem_fwd;
      FWD_MEMWB: ex_b = wb_data;
      default:   ex_b = idex_rdat2;
    endcase
  end

  assign alu_b = idex_alu_src ? idex_imm : ex_b;

  alu u_alu (
    .port_a(ex_a), .port_b(alu_b), .shamt(idex_shamt), .op(idex_alu_op),
    .result(alu_result), .zero(alu_zero)
  );

  // taken branch or any jump leaves the sequential path
  assign redirect = idex_valid & (idex_is_jump | idex_is_jr
                  | (idex_is_branch & (alu_zero ^ idex_is_bne)));

  always_comb begin
    if (idex_is_jr) ex_target = ex_a;
    else if (idex_is_jump) ex_target = {idex_pc4[`DATA_W-1:28], idex_jidx, 2'b00};
    else ex_target = idex_pc4 + {idex_imm[`DATA_W-3:0], 2'b00};
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) exmem_valid <= 1'b0;
    else if (exmem_en) exmem_valid <= idex_valid;
  end

  always_ff @(posedge CLK) begin
    if (exmem_en) begin
      exmem_reg_wen <= idex_reg_wen;
      exmem_mem_ren <= idex_mem_ren;
      exmem_mem_wen <= idex_mem_wen;
      exmem_is_halt <= idex_is_halt;
      exmem_wb_src  <= idex_wb_src;
      exmem_alu     <= alu_result;
      exmem_store   <= ex_b;  // forwarded rt
      exmem_pc4     <= idex_pc4;
      exmem_wsel    <= idex_wsel;
    end
  end

  // ------------------------------
  // memory
  assign dmem_ren   = exmem_valid & exmem_mem_ren;
  assign dmem_wen   = exmem_valid & exmem_mem_wen;
  assign dmem_addr  = exmem_alu;
  assign dmem_store = exmem_store;
  assign exmem_fwd  = (exmem_wb_src == WB_LINK) ? exmem_pc4 : exmem_alu;

  hazard_unit u_hazard (
    .ihit, .dhit, .mem_busy(dmem_ren | dmem_wen), .id_rs, .id_rt,
    .ex_load(idex_valid & idex_mem_ren), .ex_rt(idex_rt), .redirect, .halt_seen(halt_q),
    .pc_en, .ifid_en, .ifid_flush, .idex_en, .idex_bubble, .exmem_en,
    .memwb_en, .memwb_bubble
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memwb_valid <= 1'b0;
      halt_q      <= 1'b0;
    end else begin
      if (memwb_en) memwb_valid <= exmem_valid & !memwb_bubble;
      halt_q <= halt_q | (memwb_valid & memwb_is_halt);  // sticky
    end
  end

  always_ff @(posedge CLK) begin
    if (memwb_en) begin
      memwb_reg_wen <= exmem_reg_wen;
      memwb_is_halt <= exmem_is_halt;
      memwb_wb_src  <= exmem_wb_src;
      memwb_alu     <= exmem_alu;
      memwb_load    <= dmem_load;  // valid on the dhit edge
      memwb_pc4     <= exmem_pc4;
      memwb_wsel    <= exmem_wsel;
    end
  end

  // ------------------------------
  // write-back
  assign wb_wen = memwb_valid & memwb_reg_wen;
  assign halt   = halt_q;

  always_comb begin
    case (memwb_wb_src)
      WB_MEM:  wb_data = memwb_load;
      WB_LINK: wb_data = memwb_pc4;
      default: wb_data = memwb_alu;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/forwarding_unit.sv
// ------------------------------
// operand bypass select for execute, newest
// writer wins, r0 never forwards
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module forwarding_unit (
  input  logic [`REG_AW-1:0] ex_rs,
  input  logic [`REG_AW-1:0] ex_rt,
  input  logic [`REG_AW-1:0] mem_rd,
  input  logic               mem_wen,
  input  logic [`REG_AW-1:0] wb_rd,
  input  logic               wb_wen,
  output pipe_pkg::fwd_sel_t fwd_a,
  output pipe_pkg::fwd_sel_t fwd_b
);
  import pipe_pkg::*;

  function automatic fwd_sel_t pick(input logic [`REG_AW-1:0] src);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (src != '0) begin
      if (mem_wen && mem_rd == src) begin
        sel = FWD_EXMEM;  // younger of the two
      end else if (wb_wen && wb_rd == src) begin
        sel = FWD_MEMWB;
      end
    end
    return sel;
  endfunction

  assign fwd_a = pick(ex_rs);
  assign fwd_b = pick(ex_rt);

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
// ------------------------------
// stall and squash control for the five stages,
// one ranked decision per cycle
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module hazard_unit (
  input  logic               ihit,
  input  logic               dhit,
  input  logic               mem_busy,
  input  logic [`REG_AW-1:0] id_rs,
  input  logic [`REG_AW-1:0] id_rt,
  input  logic               ex_load,
  input  logic [`REG_AW-1:0] ex_rt,
  input  logic               redirect,
  input  logic               halt_seen,
  output logic               pc_en,
  output logic               ifid_en,
  output logic               ifid_flush,
  output logic               idex_en,
  output logic               idex_bubble,
  output logic               exmem_en,
  output logic               memwb_en,
  output logic               memwb_bubble
);

  logic load_use;

  // load in execute feeds the instruction in decode
  assign load_use = ex_load && (ex_rt != '0) && (ex_rt == id_rs || ex_rt == id_rt);

  always_comb begin
    pc_en        = 1'b1;
    ifid_en      = 1'b1;
    ifid_flush   = 1'b0;
    idex_en      = 1'b1;
    idex_bubble  = 1'b0;
    exmem_en     = 1'b1;
    memwb_en     = 1'b1;
    memwb_bubble = 1'b0;
    if (halt_seen) begin
      // core stopped, only write-back drains
      pc_en        = 1'b0;
      ifid_en      = 1'b0;
      idex_en      = 1'b0;
      exmem_en     = 1'b0;
      memwb_bubble = 1'b1;
    end else if (mem_busy && !dhit) begin
      pc_en    = 1'b0;  // whole pipe waits on dmem
      ifid_en  = 1'b0;
      idex_en  = 1'b0;
      exmem_en = 1'b0;
      memwb_en = 1'b0;
    end else if (redirect) begin
      ifid_flush  = 1'b1;  // two wrong-path slots
      idex_bubble = 1'b1;
    end else if (load_use) begin
      pc_en       = 1'b0;
      ifid_en     = 1'b0;
      idex_bubble = 1'b1;
    end else if (!ihit) begin
      pc_en      = 1'b0;
      ifid_flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
// ------------------------------
// instruction set encodings, shared by the
// decoder and the testbench reference model
// ------------------------------
`default_nettype none

package isa_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f  // stops the core once retired
  } opcode_t;

  // function field of R-type, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
// ------------------------------
// pipeline-internal encodings for ALU control,
// write-back source and operand forwarding
// ------------------------------
`default_nettype none

package pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_SLT, ALU_SLL, ALU_LUI
  } aluop_t;

  // what write-back puts into the register file
  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_LINK
  } wb_src_t;

  // execute operand source
  typedef enum logic [1:0] {
    FWD_REG, FWD_EXMEM, FWD_MEMWB
  } fwd_sel_t;

endpackage

`default_nettype wire

//--- hw/register_file.sv
// ------------------------------
// 32 x 32 register file, two reads, one write,
// r0 hard zero, write data visible to reads
// in the same cycle
// ------------------------------
`default_nettype none
`include "cpu_defines.svh"

module register_file (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               wen,
  input  logic [`REG_AW-1:0] wsel,
  input  logic [`DATA_W-1:0] wdat,
  input  logic [`REG_AW-1:0] rsel1,
  input  logic [`REG_AW-1:0] rsel2,
  output logic [`DATA_W-1:0] rdat1,
  output logic [`DATA_W-1:0] rdat2
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];
  logic               wr_live;

  assign wr_live = wen && (wsel != '0);  // r0 writes dropped

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // bypass so decode sees the value retiring this cycle
  assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
+incdir+bench
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/alu.sv
hw/hazard_unit.sv
hw/forwarding_unit.sv
hw/datapath.sv
bench/tb_datapath.sv

//--- run_sim.sh
#!/bin/sh
# build the datapath testbench with Verilator, run it,
# and decide pass or fail from the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_datapath -f project.f \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
